// ==== hdl/frame_consts.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes for the frame checksum unit; data width is one byte in this build
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FRAME_CONSTS_SVH
`define FRAME_CONSTS_SVH

// width of one payload word on every port
`define FRAME_DATA_W 8

// address bits of both queues giving 2**4 = 16 entries each
`define FRAME_QUEUE_AW 4

// each stored entry carries the last flag above the data bits
// so queue entries are FRAME_DATA_W+1 wide

`endif

// ==== hdl/frame_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types; entry layout is {last, data}
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "frame_consts.svh"

package frame_pkg;

    // one payload word
    typedef logic [`FRAME_DATA_W-1:0] data_word_t;

    // one queue entry, top bit is the end of frame marker
    typedef logic [`FRAME_DATA_W:0] queue_entry_t;

    // inserter FSM
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,  // nothing presented, waiting for queue data
        ST_WAIT = 2'd1,  // queue read data is presented on fwd
        ST_SUM  = 2'd2   // checksum word is presented on fwd
    } inserter_state_t;

endpackage

`default_nettype wire

// ==== hdl/word_queue.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIFO, read data valid one cycle after read_cmd; write when full is dropped
// read when empty is ignored; read_data holds until the next accepted read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module word_queue #(
    parameter int entry_width   = 9,  // bits per stored entry
    parameter int address_width = 4   // depth is 2**address_width
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   write_cmd,   // push write_data
    input  wire logic [entry_width-1:0] write_data,
    input  wire logic                   read_cmd,    // pop into read_data
    output logic      [entry_width-1:0] read_data,   // valid the cycle after read_cmd
    output logic                        full,        // no room for a write
    output logic                        empty        // nothing to read
);

    localparam int depth = 2 ** address_width;

    logic [entry_width-1:0]   mem [depth];             // storage array
    logic [address_width-1:0] front_reg, front_next;   // read pointer
    logic [address_width-1:0] rear_reg, rear_next;     // write pointer
    logic [address_width-1:0] front_inc, rear_inc;
    logic                     full_reg, full_next;
    logic                     empty_reg, empty_next;
    logic                     wr_en;                   // legal write this cycle
    logic                     rd_en;                   // legal read this cycle

    assign wr_en     = write_cmd & ~full_reg;  // write while full is lost
    assign rd_en     = read_cmd & ~empty_reg;  // read while empty does nothing
    assign front_inc = front_reg + 1'b1;       // wraps at depth
    assign rear_inc  = rear_reg + 1'b1;
    assign full      = full_reg;
    assign empty     = empty_reg;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[rear_reg] <= write_data;
        end
        if (rd_en) begin
            read_data <= mem[front_reg];  // never same slot as the write, see flags
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            front_reg <= '0;
            rear_reg  <= '0;
            full_reg  <= 1'b0;
            empty_reg <= 1'b1;  // starts empty, so in_ready is high
        end else begin
            front_reg <= front_next;
            rear_reg  <= rear_next;
            full_reg  <= full_next;
            empty_reg <= empty_next;
        end
    end

    // pointer and flag update
    // with both enables set the queue is neither empty nor full,
    // so both pointers move and the fill level stays the same
    always_comb begin
        front_next = front_reg;
        rear_next  = rear_reg;
        full_next  = full_reg;
        empty_next = empty_reg;
        case ({wr_en, rd_en})
            2'b01: begin  // read only
                front_next = front_inc;
                full_next  = 1'b0;
                empty_next = (front_inc == rear_reg);  // caught up with writer
            end
            2'b10: begin  // write only
                rear_next  = rear_inc;
                empty_next = 1'b0;
                full_next  = (rear_inc == front_reg);  // wrapped onto reader
            end
            2'b11: begin  // read and write together
                front_next = front_inc;
                rear_next  = rear_inc;
            end
            default: begin
                front_next = front_reg;  // idle
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/checksum_inserter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// appends the XOR of each frame after its last word; the queue read register
// is the output slot, so read_data must stay put until fwd accepts it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "frame_consts.svh"

module checksum_inserter (
    input  wire logic                    clk,
    input  wire logic                    reset,
    output logic                         read_cmd,   // pop ingress queue
    input  wire logic                    empty,      // ingress queue empty
    input  wire frame_pkg::queue_entry_t read_data,  // entry, one cycle after read_cmd
    output logic                         fwd_valid,
    input  wire logic                    fwd_ready,
    output frame_pkg::data_word_t        fwd_data,
    output logic                         fwd_last
);

    frame_pkg::inserter_state_t state, state_next;
    frame_pkg::data_word_t      sum, sum_next;  // running XOR of the frame
    frame_pkg::data_word_t      entry_data;
    logic                       entry_last;
    logic                       accept;          // fwd word taken this cycle

    assign entry_data = read_data[`FRAME_DATA_W-1:0];
    assign entry_last = read_data[`FRAME_DATA_W];
    assign accept     = fwd_valid & fwd_ready;

    // output slot: data words go out with last cleared, the checksum carries it
    always_comb begin
        fwd_valid = (state != frame_pkg::ST_IDLE);
        fwd_data  = (state == frame_pkg::ST_SUM) ? sum : entry_data;
        fwd_last  = (state == frame_pkg::ST_SUM);
    end

    always_comb begin
        state_next = state;
        sum_next   = sum;
        read_cmd   = 1'b0;
        case (state)
            frame_pkg::ST_IDLE: begin
                if (!empty) begin  // slot is free here
                    read_cmd   = 1'b1;
                    state_next = frame_pkg::ST_WAIT;
                end
            end
            frame_pkg::ST_WAIT: begin
                if (accept) begin
                    sum_next = sum ^ entry_data;
                    if (entry_last) begin
                        state_next = frame_pkg::ST_SUM;  // checksum next cycle
                    end else if (!empty) begin
                        read_cmd   = 1'b1;  // refill slot, stay in ST_WAIT
                    end else begin
                        state_next = frame_pkg::ST_IDLE;
                    end
                end
            end
            frame_pkg::ST_SUM: begin
                if (accept) begin
                    sum_next = '0;  // next frame starts fresh
                    if (!empty) begin
                        read_cmd   = 1'b1;
                        state_next = frame_pkg::ST_WAIT;
                    end else begin
                        state_next = frame_pkg::ST_IDLE;
                    end
                end
            end
            default: begin
                state_next = frame_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= frame_pkg::ST_IDLE;  // fwd_valid low
            sum   <= '0;
        end else begin
            state <= state_next;
            sum   <= sum_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/frame_egress.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output buffer; fwd_ready is the queue not-full flag, out_* is registered
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "frame_consts.svh"

module frame_egress (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  fwd_valid,
    output logic                       fwd_ready,
    input  wire frame_pkg::data_word_t fwd_data,
    input  wire logic                  fwd_last,
    output logic                       out_valid,
    input  wire logic                  out_ready,
    output frame_pkg::data_word_t      out_data,
    output logic                       out_last
);

    frame_pkg::queue_entry_t q_read_data;  // queue read register
    frame_pkg::queue_entry_t out_entry;    // prefetch register
    logic                    q_read_cmd;
    logic                    q_full;
    logic                    q_empty;
    logic                    rd_valid;     // q_read_data holds an entry not yet moved
    logic                    move;         // q_read_data into out_entry this cycle

    word_queue #(
        .entry_width  ($bits(frame_pkg::queue_entry_t)),
        .address_width(`FRAME_QUEUE_AW)
    ) i_queue (
        .clk       (clk),
        .reset     (reset),
        .write_cmd (fwd_valid),             // dropped inside when full
        .write_data({fwd_last, fwd_data}),
        .read_cmd  (q_read_cmd),
        .read_data (q_read_data),
        .full      (q_full),
        .empty     (q_empty)
    );

    assign fwd_ready  = ~q_full;
    assign move       = rd_valid & (~out_valid | out_ready);  // register free or draining
    assign q_read_cmd = ~q_empty & (~rd_valid | move);        // keep the read stage busy
    assign out_data   = out_entry[`FRAME_DATA_W-1:0];
    assign out_last   = out_entry[`FRAME_DATA_W];

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            rd_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (q_read_cmd) begin
                rd_valid <= 1'b1;  // new entry lands next cycle
            end else if (move) begin
                rd_valid <= 1'b0;
            end
            if (move) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;  // taken, nothing behind it
            end
        end
    end

    always_ff @(posedge clk) begin
        if (move) begin
            out_entry <= q_read_data;  // only loads when empty or accepted
        end
    end

endmodule

`default_nettype wire

// ==== hdl/frame_checksum_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// in_ready is the ingress queue not-full flag; input to output latency varies
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "frame_consts.svh"

module frame_checksum_top (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  in_valid,
    output logic                       in_ready,
    input  wire frame_pkg::data_word_t in_data,
    input  wire logic                  in_last,
    output logic                       out_valid,
    input  wire logic                  out_ready,
    output frame_pkg::data_word_t      out_data,
    output logic                       out_last
);

    frame_pkg::queue_entry_t ing_read_data;
    logic                    ing_read_cmd;
    logic                    ing_full;
    logic                    ing_empty;
    logic                    fwd_valid;
    logic                    fwd_ready;
    frame_pkg::data_word_t   fwd_data;
    logic                    fwd_last;

    assign in_ready = ~ing_full;

    word_queue #(
        .entry_width  (`FRAME_DATA_W + 1),  // {last, data}
        .address_width(`FRAME_QUEUE_AW)
    ) i_ingress (
        .clk       (clk),
        .reset     (reset),
        .write_cmd (in_valid),
        .write_data({in_last, in_data}),
        .read_cmd  (ing_read_cmd),
        .read_data (ing_read_data),
        .full      (ing_full),
        .empty     (ing_empty)
    );

    checksum_inserter i_inserter (
        .clk      (clk),
        .reset    (reset),
        .read_cmd (ing_read_cmd),
        .empty    (ing_empty),
        .read_data(ing_read_data),
        .fwd_valid(fwd_valid),
        .fwd_ready(fwd_ready),
        .fwd_data (fwd_data),
        .fwd_last (fwd_last)
    );

    frame_egress i_egress (
        .clk      (clk),
        .reset    (reset),
        .fwd_valid(fwd_valid),
        .fwd_ready(fwd_ready),
        .fwd_data (fwd_data),
        .fwd_last (fwd_last),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data (out_data),
        .out_last (out_last)
    );

endmodule

`default_nettype wire

// ==== test/frame_checksum_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output handshake assertions, bound into every frame_checksum_top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module frame_checksum_checker (
    input wire logic                  clk,
    input wire logic                  reset,
    input wire logic                  out_valid,
    input wire logic                  out_ready,
    input wire frame_pkg::data_word_t out_data,
    input wire logic                  out_last
);

    int unsigned fail_count = 0;  // failed assertion count

    // a word that is offered but not taken must not change
    hold_stable: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> ($stable(out_data) && $stable(out_last)))
    else begin
        fail_count++;
        $error("out_data or out_last changed while out_ready was low");
    end

    // nothing offered while in reset
    quiet_in_reset: assert property (@(posedge clk) reset |-> !out_valid)
    else begin
        fail_count++;
        $error("out_valid high during reset");
    end

    valid_known: assert property (@(posedge clk) !$isunknown(out_valid))
    else begin
        fail_count++;
        $error("out_valid is unknown");
    end

endmodule

bind frame_checksum_top frame_checksum_checker i_checker (
    .clk      (clk),
    .reset    (reset),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data),
    .out_last (out_last)
);

`default_nettype wire

// ==== test/frame_checksum_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// table driven tests run in order; each test drains the DUT before the next
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "frame_consts.svh"
`default_nettype none

module frame_checksum_tb;

    localparam int NUM_TESTS      = 5;
    localparam int NUM_FRAMES     = 12;
    localparam int READY_ON       = 0;     // out_ready always high
    localparam int READY_RAND     = 1;     // out_ready from the LFSR
    localparam int READY_HOLD     = 2;     // low until in_ready falls
    localparam int INPUT_TIMEOUT  = 2000;  // cycles per input word
    localparam int OUTPUT_TIMEOUT = 1000;  // idle cycles on the output
    localparam int FILL_TIMEOUT   = 300;   // cycles for in_ready to fall

    logic                    clk;
    logic                    reset;
    logic                    in_valid;
    logic                    in_ready;
    frame_pkg::data_word_t   in_data;
    logic                    in_last;
    logic                    out_valid;
    logic                    out_ready;
    frame_pkg::data_word_t   out_data;
    logic                    out_last;

    logic [31:0]             lfsr;           // random source, one step per bit
    logic                    hold_released;  // lets out_ready rise in hold mode
    int                      errors;
    int                      words_total;
    frame_pkg::queue_entry_t in_q [$];       // {last, data} to send
    frame_pkg::queue_entry_t exp_q [$];      // {last, data} expected out

    // test table: name, first frame, frame count, out_ready mode
    string test_name [NUM_TESTS] = '{
        "single five word frame", "back to back frames", "one word frame",
        "random out_ready", "out_ready held low"};
    int test_first [NUM_TESTS] = '{0, 1, 4, 5, 9};
    int test_count [NUM_TESTS] = '{1, 3, 1, 4, 3};
    int test_mode  [NUM_TESTS] = '{READY_ON, READY_ON, READY_ON, READY_RAND, READY_HOLD};

    // frame table: length, index into word_tab (-1 random), checksum (-1 from model)
    int frame_len  [NUM_FRAMES] = '{5, 3, 2, 4, 1, 4, 1, 9, 6, 16, 14, 12};
    int frame_base [NUM_FRAMES] = '{0, 5, 8, 10, 14, -1, -1, -1, -1, -1, -1, -1};
    int frame_sum  [NUM_FRAMES] = '{'h11, 'h07, 'h30, 'h3f, 'ha5, -1, -1, -1, -1, -1, -1, -1};
    frame_pkg::data_word_t word_tab [15] = '{
        8'h11, 8'h22, 8'h33, 8'h44, 8'h55,  // frame 0
        8'h01, 8'h02, 8'h04,                // frame 1
        8'h10, 8'h20,                       // frame 2, sum would be 37 without restart
        8'h80, 8'h40, 8'h0f, 8'hf0,         // frame 3
        8'ha5};                             // one word frame

    frame_checksum_top i_frame_checksum_top (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (in_data),
        .in_last  (in_last),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data (out_data),
        .out_last (out_last)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 100 MHz
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic random_bits(input int n, output frame_pkg::data_word_t value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[`FRAME_DATA_W-2:0], lfsr[0]};  // newest bit at the bottom
        end
    endtask

    task automatic abort_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("Done: errors found");
        $finish;
    endtask

    // reference model: data words pass with last cleared, then the XOR with last set
    task automatic build_test(input int t);
        frame_pkg::data_word_t word;
        frame_pkg::data_word_t sum;
        int                    f;
        in_q.delete();
        exp_q.delete();
        for (int k = 0; k < test_count[t]; k++) begin
            f   = test_first[t] + k;
            sum = '0;  // every frame starts from zero
            for (int i = 0; i < frame_len[f]; i++) begin
                if (frame_base[f] < 0) begin
                    random_bits(`FRAME_DATA_W, word);
                end else begin
                    word = word_tab[frame_base[f] + i];
                end
                in_q.push_back({(i == frame_len[f] - 1), word});
                exp_q.push_back({1'b0, word});
                sum ^= word;
            end
            if (frame_sum[f] >= 0) begin
                sum = frame_sum[f][`FRAME_DATA_W-1:0];  // hand computed value
            end
            exp_q.push_back({1'b1, sum});
        end
    endtask

    task automatic drive_input();
        frame_pkg::queue_entry_t entry;
        int                      wait_cycles;
        while (in_q.size() > 0) begin
            entry = in_q.pop_front();
            in_valid <= 1'b1;
            in_data  <= entry[`FRAME_DATA_W-1:0];
            in_last  <= entry[`FRAME_DATA_W];
            wait_cycles = 0;
            do begin
                @(posedge clk);
                wait_cycles++;
            end while (!in_ready && wait_cycles < INPUT_TIMEOUT);  // word taken when high
            if (!in_ready) begin
                abort_run("in_ready stayed low, an input word was never accepted");
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic check_output(input int mode);
        frame_pkg::queue_entry_t expected;
        frame_pkg::data_word_t   rnd;
        int                      idle;
        idle = 0;
        while (exp_q.size() > 0) begin
            case (mode)
                READY_RAND: begin
                    random_bits(1, rnd);
                    out_ready <= rnd[0];
                end
                READY_HOLD: out_ready <= hold_released;
                default:    out_ready <= 1'b1;
            endcase
            @(posedge clk);
            if (out_valid && out_ready) begin  // values seen at this edge
                expected = exp_q.pop_front();
                assert (out_data === expected[`FRAME_DATA_W-1:0]) else begin
                    $display("FAIL time %0t out_data got %h expected %h",
                             $time, out_data, expected[`FRAME_DATA_W-1:0]);
                    errors++;
                end
                assert (out_last === expected[`FRAME_DATA_W]) else begin
                    $display("FAIL time %0t out_last got %b expected %b",
                             $time, out_last, expected[`FRAME_DATA_W]);
                    errors++;
                end
                words_total++;
                idle = 0;
            end else begin
                idle++;
                if (idle > OUTPUT_TIMEOUT) begin
                    abort_run("output stalled before all expected words arrived");
                end
            end
        end
    endtask

    // hold mode: keep out_ready low until the input side pushes back
    task automatic release_when_full();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (in_ready && cycles < FILL_TIMEOUT);
        if (in_ready) begin
            abort_run("in_ready did not fall while out_ready was held low");
        end
        hold_released <= 1'b1;  // monitor sees it from the next edge
    endtask

    initial begin
        int test_errors;
        int test_words;
        int total_errors;
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_data       = '0;
        in_last       = 1'b0;
        out_ready     = 1'b0;
        hold_released = 1'b0;
        lfsr          = 32'hfb9622ed;
        errors        = 0;
        words_total   = 0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        for (int t = 0; t < NUM_TESTS; t++) begin
            build_test(t);
            test_errors   = errors;
            test_words    = words_total;
            hold_released = 1'b0;
            fork
                drive_input();
                check_output(test_mode[t]);
                begin
                    if (test_mode[t] == READY_HOLD) begin
                        release_when_full();
                    end
                end
            join
            $display("test %0d (%s): %0d words checked, %0d errors",
                     t + 1, test_name[t], words_total - test_words, errors - test_errors);
        end

        // nothing may follow the last checksum word
        out_ready <= 1'b1;
        repeat (20) begin
            @(posedge clk);
            assert (!(out_valid && out_ready)) else begin
                $display("unexpected extra output word %h after the last frame", out_data);
                errors++;
            end
        end

        total_errors = errors + i_frame_checksum_top.i_checker.fail_count;
        $display("%0d tests, %0d words checked, %0d errors",
                 NUM_TESTS, words_total, total_errors);
        if (total_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hdl
hdl/frame_pkg.sv
hdl/word_queue.sv
hdl/checksum_inserter.sv
hdl/frame_egress.sv
hdl/frame_checksum_top.sv
test/frame_checksum_checker.sv
test/frame_checksum_tb.sv

// ==== Bender.yml ====
package:
  name: frame_checksum

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/frame_pkg.sv
      - hdl/word_queue.sv
      - hdl/checksum_inserter.sv
      - hdl/frame_egress.sv
      - hdl/frame_checksum_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/frame_checksum_checker.sv
      - test/frame_checksum_tb.sv
